//--- Makefile
# Verilator build and run of the core testbench

SIM = obj_dir/core_sim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module core_tb -o core_sim

run: build
	./$(SIM) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module core_tb
	verilator --lint-only rtl/isa_pkg.sv rtl/fetch_pkg.sv rtl/pc_unit.sv \
		rtl/inst_decode.sv rtl/int_execute.sv rtl/reg_result.sv rtl/core_top.sv \
		--top-module core_top

clean:
	rm -rf obj_dir sim.log

//--- flist.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/pc_unit.sv
rtl/inst_decode.sv
rtl/int_execute.sv
rtl/reg_result.sv
rtl/core_top.sv
tests/tb_clock.sv
tests/core_tb.sv

//--- rtl/core_top.sv
/*
 * Core top: pc unit, decode, execute and result stages wired together.
 * Exposes the instruction-memory handshake and the retire port.
 */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    output logic                               inst_ready,
    input  wire logic                          inst_valid,
    input  wire logic [isa_pkg::xlen-1:0]      inst_data,
    output logic      [isa_pkg::xlen-1:0]      inst_addr,
    output logic                               retire_valid,
    output logic      [isa_pkg::xlen-1:0]      retire_pc,
    output logic      [isa_pkg::reg_idx_w-1:0] retire_rd,
    output logic                               retire_we,
    output logic      [isa_pkg::xlen-1:0]      retire_data
);

    logic                          redirect;
    logic [isa_pkg::xlen-1:0]      redirect_pc;
    logic                          if_valid;
    logic                          if_ready;
    logic [isa_pkg::xlen-1:0]      if_inst;
    logic [isa_pkg::xlen-1:0]      if_pc;
    logic                          id_valid;
    logic                          id_ready;
    isa_pkg::alu_op_e              id_op;
    logic [isa_pkg::reg_idx_w-1:0] id_rd;
    logic [isa_pkg::reg_idx_w-1:0] id_rs1;
    logic [isa_pkg::reg_idx_w-1:0] id_rs2;
    logic [isa_pkg::xlen-1:0]      id_imm;
    logic [isa_pkg::xlen-1:0]      id_pc;
    logic [isa_pkg::xlen-1:0]      rs1_data;
    logic [isa_pkg::xlen-1:0]      rs2_data;
    logic                          ex_valid;
    logic [isa_pkg::reg_idx_w-1:0] ex_rd;
    logic                          ex_we;
    logic [isa_pkg::xlen-1:0]      ex_data;
    logic [isa_pkg::xlen-1:0]      ex_pc;

    pc_unit u_pc_unit (
        .clk, .rst, .redirect, .redirect_pc,
        .inst_ready, .inst_valid, .inst_data, .inst_addr,
        .if_valid, .if_ready, .if_inst, .if_pc
    );

    inst_decode u_inst_decode (
        .clk, .rst,
        .flush (redirect),   // taken branch kills the decode slot
        .if_valid, .if_inst, .if_pc, .if_ready,
        .id_valid, .id_op, .id_rd, .id_rs1, .id_rs2, .id_imm, .id_pc, .id_ready
    );

    int_execute u_int_execute (
        .clk, .rst,
        .id_valid, .id_op, .id_rd, .id_rs1, .id_rs2, .id_imm, .id_pc, .id_ready,
        .rs1_data, .rs2_data, .redirect, .redirect_pc,
        .ex_valid, .ex_rd, .ex_we, .ex_data, .ex_pc
    );

    reg_result u_reg_result (
        .clk, .rst,
        .ex_valid, .ex_rd, .ex_we, .ex_data, .ex_pc,
        .rs1_idx (id_rs1),   // read straight from the decode register
        .rs2_idx (id_rs2),
        .rs1_data, .rs2_data,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
    );

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
/*
 * Fetch-side constants and the pc unit state encoding.
 * Compile after isa_pkg; referenced by scoped name.
 */
`default_nettype none

package fetch_pkg;

    localparam logic [isa_pkg::xlen-1:0] reset_pc   = 32'h8000_0000; // first fetch
    localparam logic [isa_pkg::xlen-1:0] inst_bytes = 4;             // no compressed

    typedef enum logic [1:0] {
        st_fetching, // ready high, live fetch outstanding
        st_stale,    // ready high, answer belongs to the old path
        st_idle      // ready low, holding an instruction or one gap cycle
    } fetch_state_e;

endpackage

`default_nettype wire

//--- rtl/inst_decode.sv
/*
 * Decode register stage. Splits the fetched word into an operation,
 * register indices and a sign-extended immediate, one instruction deep.
 * Flush from execute empties the stage.
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          flush,
    input  wire logic                          if_valid,
    input  wire logic [isa_pkg::xlen-1:0]      if_inst,
    input  wire logic [isa_pkg::xlen-1:0]      if_pc,
    output logic                               if_ready,
    output logic                               id_valid,
    output isa_pkg::alu_op_e                   id_op,
    output logic      [isa_pkg::reg_idx_w-1:0] id_rd,
    output logic      [isa_pkg::reg_idx_w-1:0] id_rs1,
    output logic      [isa_pkg::reg_idx_w-1:0] id_rs2,
    output logic      [isa_pkg::xlen-1:0]      id_imm,
    output logic      [isa_pkg::xlen-1:0]      id_pc,
    input  wire logic                          id_ready
);

    isa_pkg::alu_op_e              dec_op;
    logic [isa_pkg::reg_idx_w-1:0] dec_rs2;
    logic [isa_pkg::xlen-1:0]      dec_imm;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic                          if_fire;

    assign funct3 = if_inst[14:12];
    assign funct7 = if_inst[31:25];

    assign if_ready = !id_valid || id_ready; // single entry
    assign if_fire  = if_valid && if_ready;

    always_comb begin
        dec_op  = isa_pkg::alu_nop;
        dec_rs2 = if_inst[24:20];
        dec_imm = '0;
        case (isa_pkg::opcode_e'(if_inst[6:0]))
            isa_pkg::op_imm: begin
                dec_imm = {{20{if_inst[31]}}, if_inst[31:20]};    // I
                dec_rs2 = '0;                                     // ADDI adds x0
                if (funct3 == isa_pkg::f3_add_sub) begin
                    dec_op = isa_pkg::alu_add;
                end
            end
            isa_pkg::op_reg: begin
                if (funct3 == isa_pkg::f3_add_sub && funct7 == isa_pkg::f7_base) begin
                    dec_op = isa_pkg::alu_add;
                end else if (funct3 == isa_pkg::f3_add_sub && funct7 == isa_pkg::f7_sub) begin
                    dec_op = isa_pkg::alu_sub;
                end else if (funct3 == isa_pkg::f3_xor && funct7 == isa_pkg::f7_base) begin
                    dec_op = isa_pkg::alu_xor;
                end
            end
            isa_pkg::op_lui: begin
                dec_op  = isa_pkg::alu_pass_imm;
                dec_imm = {if_inst[31:12], 12'b0};                // U
            end
            isa_pkg::op_branch: begin
                dec_imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                           if_inst[30:25], if_inst[11:8], 1'b0};  // B
                if (funct3 == isa_pkg::f3_beq) begin
                    dec_op = isa_pkg::alu_beq;
                end else if (funct3 == isa_pkg::f3_bne) begin
                    dec_op = isa_pkg::alu_bne;
                end
            end
            isa_pkg::op_jal: begin
                dec_op  = isa_pkg::alu_jal;
                dec_imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12],
                           if_inst[20], if_inst[30:21], 1'b0};    // J
            end
            default: dec_op = isa_pkg::alu_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_valid <= 1'b0;
        end else if (if_fire) begin
            id_valid <= 1'b1;
        end else if (id_ready) begin
            id_valid <= 1'b0; // taken, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (if_fire) begin
            id_op  <= dec_op;
            id_rd  <= if_inst[11:7];
            id_rs1 <= if_inst[19:15];
            id_rs2 <= dec_rs2;
            id_imm <= dec_imm;
            id_pc  <= if_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/int_execute.sv
/*
 * Execute stage. Picks operands from the register file or its own
 * output register, computes the ALU result or JAL link, resolves BEQ/BNE
 * and raises redirect for taken control flow in the accepting cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module int_execute (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          id_valid,
    input  wire isa_pkg::alu_op_e              id_op,
    input  wire logic [isa_pkg::reg_idx_w-1:0] id_rd,
    input  wire logic [isa_pkg::reg_idx_w-1:0] id_rs1,
    input  wire logic [isa_pkg::reg_idx_w-1:0] id_rs2,
    input  wire logic [isa_pkg::xlen-1:0]      id_imm,
    input  wire logic [isa_pkg::xlen-1:0]      id_pc,
    output logic                               id_ready,
    input  wire logic [isa_pkg::xlen-1:0]      rs1_data,
    input  wire logic [isa_pkg::xlen-1:0]      rs2_data,
    output logic                               redirect,
    output logic      [isa_pkg::xlen-1:0]      redirect_pc,
    output logic                               ex_valid,
    output logic      [isa_pkg::reg_idx_w-1:0] ex_rd,
    output logic                               ex_we,
    output logic      [isa_pkg::xlen-1:0]      ex_data,
    output logic      [isa_pkg::xlen-1:0]      ex_pc
);

    logic                     redirect_q;
    logic                     accept;
    logic                     taken;
    logic                     writes_rd;
    logic [isa_pkg::xlen-1:0] op_a;
    logic [isa_pkg::xlen-1:0] op_b;
    logic [isa_pkg::xlen-1:0] result;

    assign id_ready = 1'b1;                   // result stage never stalls
    assign accept   = id_valid && !redirect_q; // wrong-path slot after redirect

    // ex_we is never set for x0, so x0 is never forwarded
    assign op_a = (ex_valid && ex_we && ex_rd == id_rs1) ? ex_data : rs1_data;
    assign op_b = (ex_valid && ex_we && ex_rd == id_rs2) ? ex_data : rs2_data;

    always_comb begin
        result    = '0;
        taken     = 1'b0;
        writes_rd = 1'b1;
        case (id_op)
            isa_pkg::alu_add:      result = op_a + op_b + id_imm; // imm is 0 for ADD
            isa_pkg::alu_sub:      result = op_a - op_b;
            isa_pkg::alu_xor:      result = op_a ^ op_b;
            isa_pkg::alu_pass_imm: result = id_imm;
            isa_pkg::alu_beq: begin
                taken     = (op_a == op_b);
                writes_rd = 1'b0;
            end
            isa_pkg::alu_bne: begin
                taken     = (op_a != op_b);
                writes_rd = 1'b0;
            end
            isa_pkg::alu_jal: begin
                result = id_pc + fetch_pkg::inst_bytes; // link
                taken  = 1'b1;
            end
            default: writes_rd = 1'b0; // nop
        endcase
    end

    assign redirect    = accept && taken;
    assign redirect_pc = id_pc + id_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid   <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            ex_valid   <= accept;
            redirect_q <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_rd   <= id_rd;
            ex_we   <= writes_rd && (id_rd != '0);
            ex_data <= result;
            ex_pc   <= id_pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
/*
 * RV32 integer subset definitions: widths, register count, the major
 * opcodes decode recognizes and the operation codes passed to execute.
 * RTL files refer to these by scoped name, for example isa_pkg::xlen.
 */
`default_nettype none

package isa_pkg;

    localparam int xlen      = 32;                // data and address width
    localparam int reg_count = 32;                // x0..x31
    localparam int reg_idx_w = $clog2(reg_count); // register index width

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // operation from decode to execute
    typedef enum logic [2:0] {
        alu_add,      // rs1 + rs2 + imm, covers ADD and ADDI
        alu_sub,
        alu_xor,
        alu_pass_imm, // LUI
        alu_beq,
        alu_bne,
        alu_jal,
        alu_nop       // anything unsupported
    } alu_op_e;

    // funct fields
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

endpackage

`default_nettype wire

//--- rtl/pc_unit.sv
/*
 * Program counter and instruction-fetch handshake. One fetch is in
 * flight at a time; the answer is held until decode takes it. A redirect
 * during an outstanding fetch turns that answer stale. It is taken and
 * dropped, then ready stays low for a cycle before the target is fetched.
 */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     redirect,
    input  wire logic [isa_pkg::xlen-1:0] redirect_pc,
    output logic                          inst_ready,
    input  wire logic                     inst_valid,
    input  wire logic [isa_pkg::xlen-1:0] inst_data,
    output logic      [isa_pkg::xlen-1:0] inst_addr,
    output logic                          if_valid,
    input  wire logic                     if_ready,
    output logic      [isa_pkg::xlen-1:0] if_inst,
    output logic      [isa_pkg::xlen-1:0] if_pc
);

    fetch_pkg::fetch_state_e state;

    logic [isa_pkg::xlen-1:0] pc;
    logic [isa_pkg::xlen-1:0] pending_pc; // target parked while stale answer drains
    logic [isa_pkg::xlen-1:0] inst_buf;
    logic                     buf_valid;
    logic                     mem_fire;
    logic                     if_fire;

    assign inst_ready = (state == fetch_pkg::st_fetching) || (state == fetch_pkg::st_stale);
    assign inst_addr  = pc;       // pc frozen while a fetch is out
    assign mem_fire   = inst_valid && inst_ready;
    assign if_fire    = if_valid && if_ready;

    assign if_valid = buf_valid;
    assign if_inst  = inst_buf;
    assign if_pc    = pc;         // pc only moves after decode takes it

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_pkg::st_fetching;
            pc        <= fetch_pkg::reset_pc;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::st_fetching: begin
                    if (redirect) begin
                        if (mem_fire) begin
                            pc <= redirect_pc;       // answer arrived with redirect and is dropped
                        end else begin
                            state <= fetch_pkg::st_stale;
                        end
                    end else if (mem_fire) begin
                        buf_valid <= 1'b1;
                        state     <= fetch_pkg::st_idle;
                    end
                end
                fetch_pkg::st_stale: begin
                    if (mem_fire) begin
                        pc    <= pending_pc;         // stale word discarded here
                        state <= fetch_pkg::st_idle; // one cycle with ready low
                    end
                end
                fetch_pkg::st_idle: begin
                    if (redirect) begin
                        pc        <= redirect_pc;
                        buf_valid <= 1'b0;           // held word is wrong path
                        state     <= fetch_pkg::st_fetching;
                    end else if (if_fire) begin
                        pc        <= pc + fetch_pkg::inst_bytes;
                        buf_valid <= 1'b0;
                        state     <= fetch_pkg::st_fetching;
                    end else if (!buf_valid) begin
                        state <= fetch_pkg::st_fetching; // gap after stale drop
                    end
                end
                default: state <= fetch_pkg::st_fetching;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            pending_pc <= redirect_pc;
        end
        if (mem_fire) begin
            inst_buf <= inst_data;
        end
    end

    // stale answer taken means decode sees nothing while ready drops for
    // one cycle and pc already holds the parked target
    a_stale_dropped: assert property (
        @(posedge clk) disable iff (rst)
        (state == fetch_pkg::st_stale && mem_fire) |=>
            (!if_valid && !inst_ready && inst_addr == $past(pending_pc))
    );

endmodule

`default_nettype wire

//--- rtl/reg_result.sv
/*
 * Register file with write-back from execute and the retire port.
 * Reads are combinational for execute; x0 always reads zero.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_result (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          ex_valid,
    input  wire logic [isa_pkg::reg_idx_w-1:0] ex_rd,
    input  wire logic                          ex_we,
    input  wire logic [isa_pkg::xlen-1:0]      ex_data,
    input  wire logic [isa_pkg::xlen-1:0]      ex_pc,
    input  wire logic [isa_pkg::reg_idx_w-1:0] rs1_idx,
    input  wire logic [isa_pkg::reg_idx_w-1:0] rs2_idx,
    output logic      [isa_pkg::xlen-1:0]      rs1_data,
    output logic      [isa_pkg::xlen-1:0]      rs2_data,
    output logic                               retire_valid,
    output logic      [isa_pkg::xlen-1:0]      retire_pc,
    output logic      [isa_pkg::reg_idx_w-1:0] retire_rd,
    output logic                               retire_we,
    output logic      [isa_pkg::xlen-1:0]      retire_data
);

    logic [isa_pkg::xlen-1:0] regs [isa_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_we) begin
            regs[ex_rd] <= ex_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire_pc   <= ex_pc;
            retire_rd   <= ex_rd;
            retire_we   <= ex_we;
            retire_data <= ex_data;
        end
    end

    // execute clears the write enable for rd == x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        (ex_valid && ex_we) |-> (ex_rd != '0)
    );

endmodule

`default_nettype wire

//--- tests/core_tb.sv
/*
 * Core testbench. Builds random programs, serves them from a memory model
 * with random answer delays, interprets them in a reference function and
 * compares every retirement in order. Run with the flist.f sources.
 */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    logic        clk;
    logic        rst;
    logic        rst_req;
    logic        inst_ready;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic [31:0] inst_addr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;

    logic [31:0] prog [64];  // 256 bytes from reset_pc
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic        exp_we [$];
    logic [31:0] exp_data [$];

    int unsigned dly_lo, dly_hi;
    int          wait_cnt;
    logic        fired;      // transfer seen at last rising edge
    logic        checking;
    int          chk_idx, checks, errors, test_errors, tests;
    int          cycles;
    int          limit;      // cycle budget of the running test
    string       cur_test;

    tb_clock u_clock (.clk, .rst, .rst_req);

    core_top DUT (
        .clk, .rst, .inst_ready, .inst_valid, .inst_data, .inst_addr,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
    );

    function automatic logic [31:0] enc_i(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // unused words have zero opcode bits and decode as nop
    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return {addr[31:7] ^ 25'(addr[6:0]), 7'b0000000};
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - fetch_pkg::reset_pc;
        if (off[31:8] == '0) return prog[off[7:2]];
        return fill_word(addr);
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(7, 0)); // few registers give many dependencies
    endfunction

    // mode 0 alu only, 1 control heavy, 2 rd mostly x0, 3 mixed
    task automatic build_program(int mode);
        int          k;
        int unsigned kind;
        logic [4:0]  rd, rs1, rs2;
        for (int i = 0; i < 64; i++) prog[i] = fill_word(fetch_pkg::reset_pc + 32'(i * 4));
        for (int i = 1; i < 8; i++) prog[i-1] = enc_i(5'(i), 5'd0, 12'($urandom)); // known regs
        for (int i = 7; i < 47; i++) begin
            kind = (mode == 0) ? $urandom_range(4, 0) : $urandom_range(8, 0);
            if (mode == 1 && $urandom_range(1, 0) == 1) kind = $urandom_range(7, 5);
            rd  = (mode == 2 && $urandom_range(1, 0) == 1) ? 5'd0 : pick_reg();
            rs1 = pick_reg();
            rs2 = ($urandom_range(2, 0) == 0) ? rs1 : pick_reg(); // equal operands take beq
            k   = int'($urandom_range(4, 1));
            if (i + k > 47) k = 47 - i;
            case (kind)
                0: prog[i] = enc_i(rd, rs1, 12'($urandom));
                1: prog[i] = enc_r(7'h00, 3'b000, rd, rs1, rs2);
                2: prog[i] = enc_r(7'h20, 3'b000, rd, rs1, rs2);
                3: prog[i] = enc_r(7'h00, 3'b100, rd, rs1, rs2);
                4: prog[i] = {20'($urandom), rd, 7'h37};
                5: prog[i] = enc_b(3'b000, rs1, rs2, 13'(k * 4));
                6: prog[i] = enc_b(3'b001, rs1, rs2, 13'(k * 4));
                7: prog[i] = enc_j(rd, 21'(k * 4));
                default: prog[i] = {20'h00002, rd, 7'h03}; // unsupported load
            endcase
        end
        prog[47] = enc_j(5'd0, 21'd0); // self-loop ends the program
    endtask

    // reference interpreter fills the expected retire queues
    function automatic void ref_interp();
        logic [31:0] r [32];
        logic [31:0] pc, w, val, next;
        logic        wr;
        logic [4:0]  rd;
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) r[i] = '0;
        pc = fetch_pkg::reset_pc;
        for (int step = 0; step < 500; step++) begin
            w    = fetch_word(pc);
            rd   = w[11:7];
            wr   = 1'b0;
            val  = '0;
            next = pc + 32'd4;
            case (w[6:0])
                7'h13: if (w[14:12] == 3'b000) begin
                    wr  = 1'b1;
                    val = r[w[19:15]] + {{20{w[31]}}, w[31:20]};
                end
                7'h33: begin
                    wr = 1'b1;
                    if (w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
                        val = r[w[19:15]] + r[w[24:20]];
                    end else if (w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
                        val = r[w[19:15]] - r[w[24:20]];
                    end else if (w[14:12] == 3'b100 && w[31:25] == 7'h00) begin
                        val = r[w[19:15]] ^ r[w[24:20]];
                    end else begin
                        wr = 1'b0;
                    end
                end
                7'h37: begin
                    wr  = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                7'h63: if ((w[14:12] == 3'b000 && r[w[19:15]] == r[w[24:20]]) ||
                           (w[14:12] == 3'b001 && r[w[19:15]] != r[w[24:20]])) begin
                    next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
                7'h6f: begin
                    wr   = 1'b1;
                    val  = pc + 32'd4; // link
                    next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            wr = wr && (rd != 5'd0);
            if (wr) r[rd] = val;
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_we.push_back(wr);
            exp_data.push_back(val);
            if (next == pc) break; // reached the self-loop
            pc = next;
        end
    endfunction

    task automatic report_mismatch(string sig, logic [31:0] expv, logic [31:0] got);
        $display("error at %0t: %s expected %h got %h", $time, sig, expv, got);
        errors++;
        test_errors++;
    endtask

    // memory model answers after dly_lo..dly_hi cycles
    always @(posedge clk) fired <= inst_valid && inst_ready;

    always @(negedge clk) begin
        if (rst) begin
            inst_valid = 1'b0;
            wait_cnt   = int'($urandom_range(dly_hi, dly_lo));
        end else begin
            if (inst_valid && fired) begin
                inst_valid = 1'b0;
                wait_cnt   = int'($urandom_range(dly_hi, dly_lo));
            end
            if (!inst_valid && inst_ready) begin
                if (wait_cnt == 0) begin
                    inst_valid = 1'b1;
                    inst_data  = fetch_word(inst_addr);
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // compare each retirement in order
    always @(negedge clk) begin
        if (checking && retire_valid && chk_idx < exp_pc.size()) begin
            if (retire_pc !== exp_pc[chk_idx]) report_mismatch("retire_pc", exp_pc[chk_idx], retire_pc);
            if (retire_rd !== exp_rd[chk_idx])
                report_mismatch("retire_rd", 32'(exp_rd[chk_idx]), 32'(retire_rd));
            if (retire_we !== exp_we[chk_idx])
                report_mismatch("retire_we", 32'(exp_we[chk_idx]), 32'(retire_we));
            if (exp_we[chk_idx] && retire_data !== exp_data[chk_idx])
                report_mismatch("retire_data", exp_data[chk_idx], retire_data);
            chk_idx++;
            checks++;
        end
    end

    // watchdog on the running test
    always @(posedge clk) begin
        if (checking) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout in test %s: %0d of %0d retired after %0d cycles",
                         cur_test, chk_idx, exp_pc.size(), cycles);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    task automatic run_test(string name, int unsigned lo, int unsigned hi);
        dly_lo      = lo;
        dly_hi      = hi;
        test_errors = 0;
        cur_test    = name;
        @(negedge clk) rst_req = 1'b1;
        @(negedge clk) rst_req = 1'b0;
        while (rst) @(negedge clk);
        chk_idx  = 0;
        cycles   = 0;
        limit    = 8 * exp_pc.size() + 100;
        checking = 1'b1;
        while (chk_idx < exp_pc.size()) @(posedge clk);
        checking = 1'b0;
        tests++;
        $display("test %s: %0d retired, %0d errors", name, chk_idx, test_errors);
    endtask

    initial begin
        rst_req    = 1'b0;
        inst_valid = 1'b0;
        inst_data  = '0;
        checking   = 1'b0;
        dly_lo     = 0;
        dly_hi     = 3;
        wait_cnt   = 0;
        cycles     = 0;
        limit      = 0;
        cur_test   = "reset";
        {chk_idx, checks, errors, test_errors, tests} = '0;
        void'($urandom(32'h7da3));
        build_program(0);
        ref_interp();

        // nothing retires in reset, first fetch at reset_pc
        do begin
            @(negedge clk);
            if (retire_valid !== 1'b0) report_mismatch("retire_valid", 32'd0, 32'(retire_valid));
        end while (rst);
        if (inst_addr !== fetch_pkg::reset_pc)
            report_mismatch("inst_addr", fetch_pkg::reset_pc, inst_addr);
        if (inst_ready !== 1'b1) report_mismatch("inst_ready", 32'd1, 32'(inst_ready));
        tests++;
        $display("test reset: %0d errors", test_errors);

        run_test("alu", 0, 3);
        build_program(1);
        ref_interp();
        run_test("control", 0, 3);
        run_test("slow_fetch", 2, 3);   // redirects land on outstanding fetches
        build_program(2);
        ref_interp();
        run_test("x0_writes", 0, 3);
        build_program(3);
        ref_interp();
        run_test("mixed_no_delay", 0, 0);
        run_test("mixed_random_delay", 0, 3);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
/*
 * Testbench clock and reset source. 8 ns clock, reset high for the
 * first 4 cycles and again for 4 cycles after each rst_req pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic    clk,
    output logic    rst,
    input  wire logic rst_req
);

    int unsigned rst_cnt = 4; // cycles of reset left

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_req) begin
            rst_cnt <= 4;
        end else if (rst_cnt != 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst = (rst_cnt != 0);

endmodule

`default_nettype wire
